/* ex_pkg.sv */
package ex_pkg;

    // pair width of every bundle; the top uses the first NUM_LANES slots
    localparam int MAX_LANES = 2;

    // codes 11 to 15 are undefined and raise INE
    typedef enum logic [3:0] {
        UOP_ADD   = 4'd0,
        UOP_SUB   = 4'd1,
        UOP_AND   = 4'd2,
        UOP_OR    = 4'd3,
        UOP_XOR   = 4'd4,
        UOP_SLT   = 4'd5,
        UOP_SLTU  = 4'd6,
        UOP_MUL   = 4'd7,
        UOP_MULH  = 4'd8,
        UOP_MULHU = 4'd9,
        UOP_PRIV  = 4'd10
    } uop_e;

    typedef enum logic [5:0] {
        ECODE_NONE = 6'h00,
        ECODE_ADEF = 6'h08,
        ECODE_INE  = 6'h0d,
        ECODE_IPE  = 6'h0e
    } ecode_e;

    typedef struct packed {
        logic [31:0] pc;
        uop_e        uop;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [4:0]  rd;
    } inst_t;

    // slot 0 holds the older instruction
    typedef struct packed {
        logic                  valid;
        inst_t [MAX_LANES-1:0] slot;
    } issue_bundle_t;

    typedef struct packed {
        logic [31:0] pc;
        uop_e        uop;
        logic [4:0]  rd;
        logic [31:0] alu_res;
        logic [31:0] mul_hh;
        logic [31:0] mul_hl;
        logic [31:0] mul_lh;
        logic [31:0] mul_ll;
        logic [31:0] mul_comp;
        ecode_e      ecode;
        logic [31:0] badv;
    } ex1_lane_t;

    typedef struct packed {
        logic                      valid;
        ex1_lane_t [MAX_LANES-1:0] lane;
    } ex1_bundle_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
    } wb_t;

    typedef struct packed {
        logic        valid;
        ecode_e      ecode;
        logic [31:0] pc;
        logic [31:0] badv;
    } excp_t;

endpackage

/* ex_stage_reg.sv */
`timescale 1ns/1ps

module ex_stage_reg #(
    parameter type payload_t = logic,
    parameter int  NUM_LANES = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     readygo_in,
    input  logic     allowin_in,
    input  payload_t din,
    output logic     allowin_out,
    output payload_t dout,
    output logic     valid
);

    // stage never stalls on its own, so back-pressure passes straight up
    assign allowin_out = allowin_in;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= 1'b0;
        end else if (allowin_in) begin
            // load on readygo, bubble otherwise
            valid <= readygo_in;
        end
    end

    // payload only moves with an accepted item
    always_ff @(posedge clk) begin
        if (allowin_in && readygo_in) begin
            dout <= din;
        end
    end

    flush_clears_valid: assert property (
        @(posedge clk) disable iff (rst)
        flush |=> !valid
    ) else $error("stage reg (%0d lanes): valid survived a flush", NUM_LANES);

    stall_holds_payload: assert property (
        @(posedge clk) disable iff (rst)
        (!allowin_in && valid) |=> $stable(dout)
    ) else $error("stage reg (%0d lanes): payload changed under stall", NUM_LANES);

endmodule

/* ex_lane.sv */
`timescale 1ns/1ps

module ex_lane (
    input  ex_pkg::inst_t     inst,
    input  logic              user_mode,
    output ex_pkg::ex1_lane_t res
);

    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] alu_res;
    logic        undef_uop;
    logic        priv_trap;
    logic        known_uop;

    assign a = inst.src_a;
    assign b = inst.src_b;

    // everything past PRIV is unassigned
    assign undef_uop = inst.uop > ex_pkg::UOP_PRIV;
    assign priv_trap = (inst.uop == ex_pkg::UOP_PRIV) && user_mode;

    // every defined micro-op code
    assign known_uop = inst.uop inside {
        ex_pkg::UOP_ADD, ex_pkg::UOP_SUB, ex_pkg::UOP_AND, ex_pkg::UOP_OR,
        ex_pkg::UOP_XOR, ex_pkg::UOP_SLT, ex_pkg::UOP_SLTU, ex_pkg::UOP_MUL,
        ex_pkg::UOP_MULH, ex_pkg::UOP_MULHU, ex_pkg::UOP_PRIV
    };

    always_comb begin
        case (inst.uop)
            ex_pkg::UOP_ADD:  alu_res = a + b;
            ex_pkg::UOP_SUB:  alu_res = a - b;
            ex_pkg::UOP_AND:  alu_res = a & b;
            ex_pkg::UOP_OR:   alu_res = a | b;
            ex_pkg::UOP_XOR:  alu_res = a ^ b;
            ex_pkg::UOP_SLT:  alu_res = {31'b0, $signed(a) < $signed(b)};
            ex_pkg::UOP_SLTU: alu_res = {31'b0, a < b};
            default:          alu_res = 32'b0;
        endcase
    end

    always_comb begin
        res.pc      = inst.pc;
        res.uop     = inst.uop;
        res.rd      = inst.rd;
        res.alu_res = alu_res;

        // four unsigned 16x16 partials of the first multiplier stage
        res.mul_hh = a[31:16] * b[31:16];
        res.mul_hl = a[31:16] * b[15:0];
        res.mul_lh = a[15:0] * b[31:16];
        res.mul_ll = a[15:0] * b[15:0];

        // signed high = unsigned high minus this term
        res.mul_comp = (a[31] ? b : 32'b0) + (b[31] ? a : 32'b0);

        // ADEF beats IPE beats INE
        res.badv = 32'b0;
        if (inst.pc[1:0] != 2'b00) begin
            res.ecode = ex_pkg::ECODE_ADEF;
            res.badv  = inst.pc;
        end else if (priv_trap) begin
            res.ecode = ex_pkg::ECODE_IPE;
        end else if (undef_uop) begin
            res.ecode = ex_pkg::ECODE_INE;
        end else begin
            res.ecode = ex_pkg::ECODE_NONE;
        end
    end

    undef_raises_excp: assert final (
        !(known_uop === 1'b0 && res.ecode === ex_pkg::ECODE_NONE))
        else $error("undefined uop %0h at pc %08h left without exception", inst.uop, inst.pc);

endmodule

/* ex2_commit.sv */
`timescale 1ns/1ps

module ex2_commit #(
    parameter int NUM_LANES = 2
) (
    input  ex_pkg::ex1_bundle_t            bundle,
    input  logic                           valid,
    input  logic                           wb_allowin,
    output ex_pkg::wb_t [NUM_LANES-1:0]    wb,
    output ex_pkg::excp_t                  excp,
    output logic                           flush
);

    logic        pair_valid;
    logic        hit;

    // register valid and the pair's own valid bit
    assign pair_valid = valid && bundle.valid;

    // second multiplier stage plus result select
    function automatic logic [31:0] lane_data(ex_pkg::ex1_lane_t l);
        logic [63:0] prod;
        prod = {l.mul_hh, 32'b0}
             + {16'b0, l.mul_hl, 16'b0}
             + {16'b0, l.mul_lh, 16'b0}
             + {32'b0, l.mul_ll};
        case (l.uop)
            ex_pkg::UOP_MUL:   lane_data = prod[31:0];
            ex_pkg::UOP_MULHU: lane_data = prod[63:32];
            ex_pkg::UOP_MULH:  lane_data = prod[63:32] - l.mul_comp;
            default:           lane_data = l.alu_res;
        endcase
    endfunction

    always_comb begin
        hit       = 1'b0;
        excp      = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            // lowest excepting lane is the oldest one
            if (!hit && bundle.lane[i].ecode != ex_pkg::ECODE_NONE) begin
                hit        = 1'b1;
                excp.ecode = bundle.lane[i].ecode;
                excp.pc    = bundle.lane[i].pc;
                excp.badv  = bundle.lane[i].badv;
            end
            // hit already covers this lane and all younger ones
            wb[i].we   = pair_valid && !hit && bundle.lane[i].uop != ex_pkg::UOP_PRIV;
            wb[i].rd   = bundle.lane[i].rd;
            wb[i].data = lane_data(bundle.lane[i]);
            wb[i].pc   = bundle.lane[i].pc;
        end
        // report only when writeback takes the pair
        excp.valid = pair_valid && hit && wb_allowin;
    end

    // exception drains everything younger
    assign flush = excp.valid;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_chk
        logic excp_at_or_before;

        // any exception in this lane or an older one
        always_comb begin
            excp_at_or_before = 1'b0;
            for (int j = 0; j <= i; j++) begin
                if (bundle.lane[j].ecode != ex_pkg::ECODE_NONE) begin
                    excp_at_or_before = 1'b1;
                end
            end
        end

        no_wb_after_excp: assert final (
            !(wb[i].we === 1'b1 && excp_at_or_before === 1'b1))
            else $error("lane %0d writes at or after an excepting lane", i);
    end

endmodule

/* ex_top.sv */
`timescale 1ns/1ps

module ex_top #(
    parameter int NUM_LANES = 2
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        user_mode,
    input  ex_pkg::issue_bundle_t       issue,
    input  logic                        issue_valid,
    input  logic                        wb_allowin,
    output logic                        issue_allowin,
    output ex_pkg::wb_t [NUM_LANES-1:0] wb,
    output ex_pkg::excp_t               excp
);

    ex_pkg::issue_bundle_t             issue_q;
    ex_pkg::ex1_bundle_t               ex1_d;
    ex_pkg::ex1_bundle_t               ex1_q;
    ex_pkg::ex1_lane_t [NUM_LANES-1:0] lane_res;
    logic                              issue_q_valid;
    logic                              ex1_q_valid;
    logic                              ex1_allowin;
    logic                              flush;

    ex_stage_reg #(
        .payload_t (ex_pkg::issue_bundle_t),
        .NUM_LANES (NUM_LANES)
    ) issue_reg (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .readygo_in  (issue_valid),
        .allowin_in  (ex1_allowin),
        .din         (issue),
        .allowin_out (issue_allowin),
        .dout        (issue_q),
        .valid       (issue_q_valid)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        ex_lane lane_inst (
            .inst      (issue_q.slot[i]),
            .user_mode (user_mode),
            .res       (lane_res[i])
        );
    end

    // unused slots stay zero, which reads as no exception
    always_comb begin
        ex1_d       = '0;
        ex1_d.valid = issue_q_valid && issue_q.valid;
        for (int i = 0; i < NUM_LANES; i++) begin
            ex1_d.lane[i] = lane_res[i];
        end
    end

    ex_stage_reg #(
        .payload_t (ex_pkg::ex1_bundle_t),
        .NUM_LANES (NUM_LANES)
    ) ex1_ex2_reg (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .readygo_in  (issue_q_valid),
        .allowin_in  (wb_allowin),
        .din         (ex1_d),
        .allowin_out (ex1_allowin),
        .dout        (ex1_q),
        .valid       (ex1_q_valid)
    );

    ex2_commit #(
        .NUM_LANES (NUM_LANES)
    ) commit_inst (
        .bundle     (ex1_q),
        .valid      (ex1_q_valid),
        .wb_allowin (wb_allowin),
        .wb         (wb),
        .excp       (excp),
        .flush      (flush)
    );

endmodule

/* tb_ex_tasks.svh */
`ifndef TB_EX_TASKS_SVH
`define TB_EX_TASKS_SVH

// aligned pc and a random nonzero rd
function automatic ex_pkg::inst_t make_inst(input ex_pkg::uop_e uop, input logic [31:0] a,
                                            input logic [31:0] b);
    ex_pkg::inst_t ins;
    ins.pc    = $urandom() & 32'hffff_fffc;
    ins.uop   = uop;
    ins.src_a = a;
    ins.src_b = b;
    ins.rd    = 5'($urandom_range(31, 1));
    return ins;
endfunction

function automatic ex_pkg::inst_t rand_inst(input int max_uop);
    return make_inst(ex_pkg::uop_e'($urandom_range(max_uop, 0)), $urandom(), $urandom());
endfunction

function automatic ex_pkg::issue_bundle_t make_pair(input ex_pkg::inst_t i0,
                                                    input ex_pkg::inst_t i1);
    ex_pkg::issue_bundle_t p;
    p.valid   = 1'b1;
    p.slot[0] = i0;
    p.slot[1] = i1;
    return p;
endfunction

// returns on the edge that took the pair
task automatic send_pair(input ex_pkg::issue_bundle_t p);
    issue       <= p;
    issue_valid <= 1'b1;
    do @(negedge clk); while (!(issue_allowin && !excp.valid));
    @(posedge clk);
endtask

task automatic drain_pipe();
    issue_valid <= 1'b0;
    do @(negedge clk); while (iss_v || ex_v);
    @(posedge clk);
endtask

task automatic check_reset_and_alu();
    cur_test = "reset_alu";
    @(negedge clk);
    check_val("lane 0 we after reset", 0, wb[0].we);
    check_val("lane 1 we after reset", 0, wb[1].we);
    check_val("excp valid after reset", 0, excp.valid);
    @(posedge clk);
    wb_allowin <= 1'b0;
    @(negedge clk);
    check_val("issue_allowin under stall", 0, issue_allowin);
    @(posedge clk);
    wb_allowin <= 1'b1;
    repeat (10) begin
        send_pair(make_pair(rand_inst(6), rand_inst(6)));
        drain_pipe();
    end
endtask

task automatic run_multiply_cases();
    logic [31:0]  corner [5] = '{32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h1, 32'h7fff_ffff};
    ex_pkg::uop_e ops [3]    = '{ex_pkg::UOP_MUL, ex_pkg::UOP_MULH, ex_pkg::UOP_MULHU};
    cur_test = "multiply";
    // operands swap between lanes so both see every order
    foreach (ops[k]) begin
        foreach (corner[i]) begin
            foreach (corner[j]) begin
                send_pair(make_pair(make_inst(ops[k], corner[i], corner[j]),
                                    make_inst(ops[k], corner[j], corner[i])));
            end
        end
    end
    repeat (10) begin
        send_pair(make_pair(make_inst(ops[$urandom_range(2, 0)], $urandom(), $urandom()),
                            make_inst(ops[$urandom_range(2, 0)], $urandom(), $urandom())));
    end
    drain_pipe();
endtask

task automatic stream_pairs();
    int start;
    cur_test = "stream";
    start    = dut_retired;
    repeat (20) begin
        send_pair(make_pair(rand_inst(9), rand_inst(9)));
    end
    drain_pipe();
    check_val("pairs retired", 20, dut_retired - start);
endtask

task automatic stall_randomly();
    int start;
    bit done;
    cur_test = "backpressure";
    start    = dut_retired;
    done     = 1'b0;
    fork
        begin
            repeat (20) begin
                send_pair(make_pair(rand_inst(9), rand_inst(9)));
            end
            issue_valid <= 1'b0;
            done = 1'b1;
        end
        begin
            // roughly one cycle in three stalled
            while (!done) begin
                @(posedge clk);
                wb_allowin <= ($urandom_range(2, 0) != 0);
            end
            wb_allowin <= 1'b1;
        end
    join
    drain_pipe();
    check_val("pairs retired", 20, dut_retired - start);
endtask

// excepting pair then two clean ones, the first of which is in flight at the flush
task automatic exception_case(input string name, input ex_pkg::issue_bundle_t p,
                              input int exp_retired);
    int start;
    cur_test = name;
    start    = dut_retired;
    send_pair(p);
    send_pair(make_pair(rand_inst(6), rand_inst(6)));
    send_pair(make_pair(rand_inst(6), rand_inst(6)));
    drain_pipe();
    check_val("pairs retired", exp_retired, dut_retired - start);
endtask

task automatic raise_exceptions();
    ex_pkg::inst_t i0;
    ex_pkg::inst_t i1;
    i1    = rand_inst(6);
    i1.pc = i1.pc | 32'h2;
    exception_case("excp_adef_lane1", make_pair(rand_inst(6), i1), 2);
    user_mode <= 1'b1;
    i0 = make_inst(ex_pkg::UOP_PRIV, 32'h0, 32'h0);
    exception_case("excp_ipe_lane0", make_pair(i0, rand_inst(6)), 2);
    i1 = make_inst(ex_pkg::uop_e'(4'hc), $urandom(), $urandom());
    exception_case("excp_ine_lane1", make_pair(rand_inst(6), i1), 2);
    // kernel mode PRIV is a silent no-op
    user_mode <= 1'b0;
    exception_case("priv_kernel", make_pair(i0, rand_inst(6)), 3);
endtask

`endif

/* tb_ex_top.sv */
`timescale 1ns/1ps

module tb_ex_top;

    localparam int NUM_LANES = 2;
    // tests need a few hundred cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                        clk;
    logic                        rst;
    logic                        user_mode;
    ex_pkg::issue_bundle_t       issue;
    logic                        issue_valid;
    logic                        wb_allowin;
    logic                        issue_allowin;
    ex_pkg::wb_t [NUM_LANES-1:0] wb;
    ex_pkg::excp_t               excp;

    int    errors;
    int    cycles;
    int    dut_retired;
    string cur_test;

    // model pipeline, queue holds the pairs in flight, oldest first
    logic                        iss_v;
    logic                        ex_v;
    ex_pkg::issue_bundle_t       exp_q[$];
    ex_pkg::wb_t [NUM_LANES-1:0] wb_prev;
    logic                        stall_prev;

    ex_top #(
        .NUM_LANES (NUM_LANES)
    ) ex_top_inst (
        .clk           (clk),
        .rst           (rst),
        .user_mode     (user_mode),
        .issue         (issue),
        .issue_valid   (issue_valid),
        .wb_allowin    (wb_allowin),
        .issue_allowin (issue_allowin),
        .wb            (wb),
        .excp          (excp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // full 64-bit products instead of partials
    function automatic logic [31:0] model_data(input ex_pkg::inst_t ins);
        logic [63:0] up;
        logic [63:0] sp;
        up = {32'b0, ins.src_a} * {32'b0, ins.src_b};
        sp = $signed({{32{ins.src_a[31]}}, ins.src_a})
           * $signed({{32{ins.src_b[31]}}, ins.src_b});
        case (ins.uop)
            ex_pkg::UOP_ADD:   return ins.src_a + ins.src_b;
            ex_pkg::UOP_SUB:   return ins.src_a - ins.src_b;
            ex_pkg::UOP_AND:   return ins.src_a & ins.src_b;
            ex_pkg::UOP_OR:    return ins.src_a | ins.src_b;
            ex_pkg::UOP_XOR:   return ins.src_a ^ ins.src_b;
            ex_pkg::UOP_SLT:   return {31'b0, $signed(ins.src_a) < $signed(ins.src_b)};
            ex_pkg::UOP_SLTU:  return {31'b0, ins.src_a < ins.src_b};
            ex_pkg::UOP_MUL:   return up[31:0];
            ex_pkg::UOP_MULH:  return sp[63:32];
            ex_pkg::UOP_MULHU: return up[63:32];
            default:           return 32'b0;
        endcase
    endfunction

    function automatic ex_pkg::ecode_e model_ecode(input ex_pkg::inst_t ins, input logic um);
        if (ins.pc[1:0] != 2'b00) begin
            return ex_pkg::ECODE_ADEF;
        end else if (ins.uop == ex_pkg::UOP_PRIV && um) begin
            return ex_pkg::ECODE_IPE;
        end else if (ins.uop > ex_pkg::UOP_PRIV) begin
            return ex_pkg::ECODE_INE;
        end
        return ex_pkg::ECODE_NONE;
    endfunction

    // NUM_LANES when the pair is clean
    function automatic int first_excp_lane(input ex_pkg::issue_bundle_t p);
        for (int i = 0; i < NUM_LANES; i++) begin
            if (model_ecode(p.slot[i], user_mode) != ex_pkg::ECODE_NONE) begin
                return i;
            end
        end
        return NUM_LANES;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
        end
    endtask

    always @(posedge clk) begin : pipe_model
        if (rst) begin
            iss_v = 1'b0;
            ex_v  = 1'b0;
            exp_q.delete();
        end else if (ex_v && wb_allowin && first_excp_lane(exp_q[0]) < NUM_LANES) begin
            // flush drops both stages and the issue on offer
            iss_v = 1'b0;
            ex_v  = 1'b0;
            exp_q.delete();
        end else if (wb_allowin) begin
            if (ex_v) begin
                void'(exp_q.pop_front());
            end
            ex_v  = iss_v;
            iss_v = issue_valid;
            if (issue_valid) begin
                exp_q.push_back(issue);
            end
        end
    end

    always @(negedge clk) begin : monitor
        int            xl;
        logic          exp_we;
        logic          exp_xv;
        ex_pkg::inst_t ins;
        if (!rst) begin
            xl = ex_v ? first_excp_lane(exp_q[0]) : NUM_LANES;
            for (int i = 0; i < NUM_LANES; i++) begin
                ins    = ex_v ? exp_q[0].slot[i] : ex_pkg::inst_t'('0);
                exp_we = ex_v && i < xl && ins.uop != ex_pkg::UOP_PRIV;
                check_val($sformatf("lane %0d we", i), exp_we, wb[i].we);
                if (exp_we) begin
                    check_val($sformatf("lane %0d data", i), model_data(ins), wb[i].data);
                    check_val($sformatf("lane %0d rd", i), ins.rd, wb[i].rd);
                    check_val($sformatf("lane %0d pc", i), ins.pc, wb[i].pc);
                end
            end
            exp_xv = xl < NUM_LANES && wb_allowin;
            check_val("excp valid", exp_xv, excp.valid);
            if (exp_xv) begin
                ins = exp_q[0].slot[xl];
                check_val("excp ecode", model_ecode(ins, user_mode), excp.ecode);
                check_val("excp pc", ins.pc, excp.pc);
                check_val("excp badv", ins.pc[1:0] != 2'b00 ? ins.pc : 32'b0, excp.badv);
            end
            check_val("issue_allowin", wb_allowin, issue_allowin);
            if (stall_prev) begin
                assert (wb === wb_prev) else begin
                    errors++;
                    $display("[FAIL] %s wb under stall: expected %h, actual %h",
                             cur_test, wb_prev, wb);
                end
            end
            // a pair leaves EX2 with a write or an exception
            if (wb_allowin && (wb[0].we || wb[1].we || excp.valid)) begin
                dut_retired++;
            end
        end
        wb_prev    = wb;
        stall_prev = !rst && !wb_allowin;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    `include "tb_ex_tasks.svh"

    initial begin
        void'($urandom(79));
        errors      = 0;
        dut_retired = 0;
        cur_test    = "reset";
        iss_v       = 1'b0;
        ex_v        = 1'b0;
        stall_prev  = 1'b0;
        rst         = 1'b1;
        user_mode   = 1'b0;
        issue       = '0;
        issue_valid = 1'b0;
        wb_allowin  = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        check_reset_and_alu();
        run_multiply_cases();
        stream_pairs();
        stall_randomly();
        raise_exceptions();
        repeat (2) @(posedge clk);
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
ex_pkg.sv
ex_stage_reg.sv
ex_lane.sv
ex2_commit.sv
ex_top.sv
tb_ex_top.sv
